//--- vlog.f
rtl/sr_map_pkg.sv
rtl/readback_pkg.sv
rtl/setting_reg.sv
rtl/misc_ctrl.sv
rtl/time_keeper.sv
rtl/readback_mux.sv
rtl/radio_ctrl_top.sv
sim/tb_radio_ctrl.sv

//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert
TOP     = tb_radio_ctrl
FLIST   = vlog.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_radio_ctrl.sv
/* Testbench for the radio control core. Drives the settings bus, status inputs and PPS,
   checks pins, LEDs and readback words, and follows VITA time with its own model. */

`timescale 1ns/1ns

module tb_radio_ctrl;

   localparam logic [31:0] TPS = 32'd40;
   // Sum of the test sections rounded up and doubled for the limit
   localparam int TEST_CYCLES = 2000;
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic                              dsp_clk;
   logic                              rst_i;
   logic                              set_stb_i;
   logic [sr_map_pkg::SET_ADDR_W-1:0] set_addr_i;
   logic [sr_map_pkg::SET_DATA_W-1:0] set_data_i;
   logic                              pps_i;
   logic                              sim_mode_i;
   logic [3:0]                        clock_divider_i;
   logic                              phy_intn_i, clk_status_i, serdes_link_up_i;
   logic                              run_rx_i, run_tx_i;
   logic [3:0]                        rb_addr_i;
   logic [31:0]                       rb_data_o;
   logic                              clock_ready_o;
   logic [1:0]                        clk_en_o;
   logic [1:0]                        clk_sel_o;
   logic                              ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic                              adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic                              phy_resetn_o;
   logic [7:0]                        leds_o;

   // Expected register contents
   logic [4:0]  w_clk;
   logic [3:0]  w_ser;
   logic [3:0]  w_adc;
   logic        w_phy;
   logic [7:0]  w_led_sw;
   logic [7:0]  w_led_src;

   int          n_errors = 0;
   int          time_errors = 0;
   int          cycles = 0;
   logic [31:0] rng = 32'h530e7356;
   logic        chk_en = 1'b0;

   // Time model state
   logic [31:0] m_secs, m_ticks, m_pend_secs, m_pend_ticks;
   logic [63:0] m_cap;
   logic        m_armed, m_load_due, m_pps_last, pps_fire;
   logic [1:0]  m_pps_cnt;
   logic [3:0]  seen_idx;
   logic [3:0]  last_idx = 4'd0;
   logic [63:0] seen_time, seen_cap;
   logic [31:0] last_lo = 32'd0;

   radio_ctrl_top #(.TICKS_PER_SEC(TPS)) u_dut (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #20 dsp_clk = ~dsp_clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic void show_mismatch(input string sig, input logic [31:0] exp_v,
                                         input logic [31:0] act_v);
      $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i <= 1'b0;
   endtask

   // Index goes out on one edge and the word is registered on the next
   task automatic read_check(input logic [3:0] idx, input logic [31:0] exp_v, input string name);
      @(posedge dsp_clk);
      rb_addr_i <= idx;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      assert (rb_data_o == exp_v) else begin
         show_mismatch(name, exp_v, rb_data_o);
         n_errors++;
      end
   endtask

   task automatic check_pins();
      logic [13:0] exp_p;
      logic [13:0] act_p;
      exp_p = {w_clk, w_ser, w_adc, ~w_phy};
      act_p = {clock_ready_o, clk_en_o, clk_sel_o, ser_enable_o, ser_prbsen_o, ser_loopen_o,
               ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o};
      assert (act_p == exp_p) else begin
         show_mismatch("control pins", {18'd0, exp_p}, {18'd0, act_p});
         n_errors++;
      end
   endtask

   task automatic check_leds();
      logic [7:0] hw;
      logic [7:0] exp_l;
      hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
      for (int b = 0; b < 8; b++)
         exp_l[b] = w_led_src[b] ? hw[b] : w_led_sw[b];
      assert (leds_o == exp_l) else begin
         show_mismatch("leds_o", {24'd0, exp_l}, {24'd0, leds_o});
         n_errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // VITA time model fed from the settings bus and PPS
   //////////////////////////////////////////////////
   always @(posedge dsp_clk) begin
      if (rst_i) begin
         {m_secs, m_ticks, m_pend_secs, m_pend_ticks} = '0;
         {m_cap, seen_time, seen_cap} = '0;
         {m_armed, m_load_due, m_pps_last} = 3'b000;
         m_pps_cnt = 2'd0;
         seen_idx  = 4'd0;
      end else begin
         // Values the readback register takes at this edge
         seen_idx  = rb_addr_i;
         seen_time = {m_secs, m_ticks};
         seen_cap  = m_cap;
         // Detect cycle ends three edges after the first high sample
         pps_fire = (m_pps_cnt == 2'd1);
         if (m_pps_cnt != 2'd0)
            m_pps_cnt = m_pps_cnt - 2'd1;
         if (pps_fire)
            m_cap = {m_secs, m_ticks};
         if (m_load_due || (pps_fire && m_armed)) begin
            m_secs  = m_pend_secs;
            m_ticks = m_pend_ticks;
         end else if (m_ticks == TPS - 32'd1) begin
            m_secs  = m_secs + 32'd1;
            m_ticks = 32'd0;
         end else begin
            m_ticks = m_ticks + 32'd1;
         end
         if (pps_fire)
            m_armed = 1'b0;
         m_load_due = 1'b0;
         if (set_stb_i && set_addr_i == sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_SECS_OFS)
            m_pend_secs = set_data_i;
         if (set_stb_i && set_addr_i == sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TICKS_OFS)
            m_pend_ticks = set_data_i;
         if (set_stb_i && set_addr_i == sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TIME_CTRL_OFS) begin
            m_load_due = set_data_i[0];
            m_armed    = ~set_data_i[0];
         end
         if (pps_i && !m_pps_last)
            m_pps_cnt = 2'd3;
         m_pps_last = pps_i;
      end
   end

   // Time words on readback checked whenever one is selected
   always @(negedge dsp_clk) begin
      logic [31:0] exp_word;
      logic        has_exp;
      has_exp = 1'b1;
      case (seen_idx)
         readback_pkg::RB_TIME_HI: exp_word = seen_time[63:32];
         readback_pkg::RB_TIME_LO: exp_word = seen_time[31:0];
         readback_pkg::RB_PPS_HI:  exp_word = seen_cap[63:32];
         readback_pkg::RB_PPS_LO:  exp_word = seen_cap[31:0];
         default: begin
            exp_word = 32'd0;
            has_exp  = 1'b0;
         end
      endcase
      if (chk_en && has_exp) begin
         assert (rb_data_o == exp_word) else begin
            show_mismatch($sformatf("rb_data_o[idx %0d]", seen_idx), exp_word, rb_data_o);
            time_errors++;
         end
      end
      if (chk_en && seen_idx == readback_pkg::RB_TIME_LO) begin
         assert (rb_data_o < TPS) else begin
            $display("Ticks value %0d at %0t ns is not below %0d", rb_data_o, $time, TPS);
            time_errors++;
         end
         if (last_idx == readback_pkg::RB_TIME_LO) begin
            assert ((rb_data_o == last_lo + 32'd1) ||
                    (last_lo == TPS - 32'd1 && rb_data_o == 32'd0)) else begin
               $display("Ticks jumped from %0d to %0d at %0t ns", last_lo, rb_data_o, $time);
               time_errors++;
            end
         end
         last_lo = rb_data_o;
      end
      last_idx = seen_idx;
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge dsp_clk);
         cycles = cycles + 1;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Errors: %0d in control and status checks, %0d in time checks",
               n_errors, time_errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   initial begin
      logic [7:0]  addr;
      logic [31:0] secs_val;
      logic [31:0] exp_mode;
      logic [31:0] exp_irq;
      rst_i <= 1'b1;
      set_stb_i <= 1'b0;
      set_addr_i <= '0;
      set_data_i <= '0;
      pps_i <= 1'b0;
      sim_mode_i <= 1'b0;
      clock_divider_i <= 4'd0;
      phy_intn_i <= 1'b0;
      clk_status_i <= 1'b1;
      serdes_link_up_i <= 1'b0;
      run_rx_i <= 1'b1;
      run_tx_i <= 1'b0;
      rb_addr_i <= 4'd0;
      w_clk = '0;
      w_ser = '0;
      w_adc = '0;
      w_phy = 1'b1;
      w_led_sw = 8'd0;
      w_led_src = sr_map_pkg::LED_SRC_AT_RESET;
      repeat (16) @(posedge dsp_clk);
      rst_i <= 1'b0;
      chk_en = 1'b1;

      // Reset values
      @(negedge dsp_clk);
      check_pins();
      check_leds();
      read_check(readback_pkg::RB_COMPAT, readback_pkg::COMPAT_NUM, "rb_data_o COMPAT");

      // Control pins with writes to unmapped addresses too
      for (int i = 0; i < 40; i++) begin
         rng = xorshift(rng);
         case (rng[31:29])
            3'd0: begin
               addr  = sr_map_pkg::SR_MISC + sr_map_pkg::SR_CLK_OFS;
               w_clk = rng[4:0];
            end
            3'd1: begin
               addr  = sr_map_pkg::SR_MISC + sr_map_pkg::SR_SER_OFS;
               w_ser = rng[3:0];
            end
            3'd2: begin
               addr  = sr_map_pkg::SR_MISC + sr_map_pkg::SR_ADC_OFS;
               w_adc = rng[3:0];
            end
            3'd3: begin
               addr  = sr_map_pkg::SR_MISC + sr_map_pkg::SR_PHY_OFS;
               w_phy = rng[0];
            end
            default: addr = 8'd16 + {1'b0, rng[28:22]};
         endcase
         write_setting(addr, rng);
         @(negedge dsp_clk);
         check_pins();
      end

      // LED source mux
      for (int i = 0; i < 20; i++) begin
         rng = xorshift(rng);
         write_setting(sr_map_pkg::SR_MISC + sr_map_pkg::SR_LED_SW_OFS, rng);
         w_led_sw = rng[7:0];
         rng = xorshift(rng);
         write_setting(sr_map_pkg::SR_MISC + sr_map_pkg::SR_LED_SRC_OFS, rng);
         w_led_src = rng[7:0];
         rng = xorshift(rng);
         @(posedge dsp_clk);
         {clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i} <= rng[3:0];
         @(negedge dsp_clk);
         check_leds();
      end

      // Immediate load with ticks read every cycle and then seconds across wraps
      rng = xorshift(rng);
      @(posedge dsp_clk);
      rb_addr_i <= readback_pkg::RB_TIME_HI;
      write_setting(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_SECS_OFS, rng);
      write_setting(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TICKS_OFS, 32'd0);
      write_setting(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TIME_CTRL_OFS, 32'd1);
      repeat (4) @(posedge dsp_clk);
      rb_addr_i <= readback_pkg::RB_TIME_LO;
      repeat (60) @(posedge dsp_clk);
      rb_addr_i <= readback_pkg::RB_TIME_HI;
      repeat (50) @(posedge dsp_clk);

      // Armed load and then PPS with the readback index rotating
      rng = xorshift(rng);
      secs_val = rng;
      write_setting(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_SECS_OFS, secs_val);
      write_setting(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TIME_CTRL_OFS, 32'd0);
      for (int i = 0; i < 80; i++) begin
         @(posedge dsp_clk);
         case (i % 4)
            0:       rb_addr_i <= readback_pkg::RB_TIME_HI;
            1:       rb_addr_i <= readback_pkg::RB_TIME_LO;
            2:       rb_addr_i <= readback_pkg::RB_PPS_HI;
            default: rb_addr_i <= readback_pkg::RB_PPS_LO;
         endcase
         if (i == 40)
            pps_i <= 1'b1;
         if (i == 48)
            pps_i <= 1'b0;
      end
      @(posedge dsp_clk);
      rb_addr_i <= readback_pkg::RB_TIME_HI;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      assert (rb_data_o == secs_val || rb_data_o == secs_val + 32'd1) else begin
         $display("Seconds %0h after the PPS load are not the armed value %0h", rb_data_o,
                  secs_val);
         n_errors++;
      end

      // Mode and interrupt words
      for (int i = 0; i < 30; i++) begin
         rng = xorshift(rng);
         @(posedge dsp_clk);
         {sim_mode_i, clock_divider_i, phy_intn_i, clk_status_i, serdes_link_up_i} <= rng[7:0];
         exp_mode = 32'd0;
         exp_mode[31] = rng[7];
         exp_mode[3:0] = rng[6:3];
         exp_irq = 32'd0;
         exp_irq[readback_pkg::IRQ_PHY_BIT] = rng[2];
         exp_irq[readback_pkg::IRQ_CLK_BIT] = rng[1];
         exp_irq[readback_pkg::IRQ_SERDES_BIT] = rng[0];
         read_check(readback_pkg::RB_MODE, exp_mode, "rb_data_o MODE");
         read_check(readback_pkg::RB_IRQ, exp_irq, "rb_data_o IRQ");
         read_check(4'd3, 32'd0, "rb_data_o index 3");
      end

      repeat (2) @(posedge dsp_clk);
      $display("Errors: %0d in control and status checks, %0d in time checks",
               n_errors, time_errors);
      if (n_errors == 0 && time_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- rtl/radio_ctrl_top.sv
/* Slow control core of the radio board on dsp_clk. Connects the settings
   bus to the control bank and the time keeper, and their results to readback. */

`timescale 1ns/1ns

module radio_ctrl_top #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input  logic                               dsp_clk,
   input  logic                               rst_i,

   // Settings bus
   input  logic                               set_stb_i,
   input  logic [sr_map_pkg::SET_ADDR_W-1:0]  set_addr_i,
   input  logic [sr_map_pkg::SET_DATA_W-1:0]  set_data_i,

   // Timing and status
   input  logic                               pps_i,
   input  logic                               sim_mode_i,
   input  logic [3:0]                         clock_divider_i,
   input  logic                               phy_intn_i,
   input  logic                               clk_status_i,
   input  logic                               serdes_link_up_i,
   input  logic                               run_rx_i,
   input  logic                               run_tx_i,

   // Readback
   input  logic [readback_pkg::RB_ADDR_W-1:0] rb_addr_i,
   output logic [31:0]                        rb_data_o,

   // Board control lines
   output logic                               clock_ready_o,
   output logic [1:0]                         clk_en_o,
   output logic [1:0]                         clk_sel_o,
   output logic                               ser_enable_o,
   output logic                               ser_prbsen_o,
   output logic                               ser_loopen_o,
   output logic                               ser_rx_en_o,
   output logic                               adc_oe_a_o,
   output logic                               adc_on_a_o,
   output logic                               adc_oe_b_o,
   output logic                               adc_on_b_o,
   output logic                               phy_resetn_o,
   output logic [7:0]                         leds_o
);

   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;
   logic        pps_int;

   //////////////////////////////////////////////////
   // Control bank
   //////////////////////////////////////////////////
   misc_ctrl u_misc_ctrl (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o)
   );

   //////////////////////////////////////////////////
   // VITA time
   //////////////////////////////////////////////////
   time_keeper #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_time_keeper (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .set_stb_i       (set_stb_i),
      .set_addr_i      (set_addr_i),
      .set_data_i      (set_data_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int)
   );

   // Status words for software
   readback_mux u_readback_mux (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .rb_addr_i        (rb_addr_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .pps_int_i        (pps_int),
      .sim_mode_i       (sim_mode_i),
      .clock_divider_i  (clock_divider_i),
      .phy_intn_i       (phy_intn_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .rb_data_o        (rb_data_o)
   );

endmodule

//--- rtl/readback_mux.sv
/* Registered readback of 16 status words. The index is sampled at a clock
   edge and the selected word appears on rb_data_o one cycle later. */

`timescale 1ns/1ns

module readback_mux (
   input  logic                               dsp_clk,
   input  logic                               rst_i,
   input  logic [readback_pkg::RB_ADDR_W-1:0] rb_addr_i,
   input  logic [63:0]                        vita_time_i,
   input  logic [63:0]                        vita_time_pps_i,
   input  logic                               pps_int_i,
   input  logic                               sim_mode_i,
   input  logic [3:0]                         clock_divider_i,
   input  logic                               phy_intn_i,
   input  logic                               clk_status_i,
   input  logic                               serdes_link_up_i,
   output logic [31:0]                        rb_data_o
);

   logic [31:0] mode_word;
   logic [31:0] irq_word;

   // Mode flag on top, clock divider in the low nibble
   assign mode_word = {sim_mode_i, 27'd0, clock_divider_i};

   // Raw interrupt sources
   always_comb begin
      irq_word = '0;
      irq_word[readback_pkg::IRQ_PHY_BIT]    = phy_intn_i;
      irq_word[readback_pkg::IRQ_PPS_BIT]    = pps_int_i;
      irq_word[readback_pkg::IRQ_SERDES_BIT] = serdes_link_up_i;
      irq_word[readback_pkg::IRQ_CLK_BIT]    = clk_status_i;
   end

   //////////////////////////////////////////////////
   // Word select
   //////////////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            readback_pkg::RB_MODE:    rb_data_o <= mode_word;
            readback_pkg::RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
            readback_pkg::RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
            readback_pkg::RB_COMPAT:  rb_data_o <= readback_pkg::COMPAT_NUM;
            readback_pkg::RB_IRQ:     rb_data_o <= irq_word;
            readback_pkg::RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
            readback_pkg::RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
            default:                  rb_data_o <= '0;
         endcase
      end
   end

endmodule

//--- rtl/time_keeper.sv
/* VITA time keeper: 32-bit seconds and ticks counting on dsp_clk, loaded at
   once or on the next PPS edge, with the time captured at every PPS edge. */

`timescale 1ns/1ns

module time_keeper #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input  logic                              dsp_clk,
   input  logic                              rst_i,
   input  logic                              set_stb_i,
   input  logic [sr_map_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [sr_map_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                              pps_i,
   output logic [63:0]                       vita_time_o,
   output logic [63:0]                       vita_time_pps_o,
   output logic                              pps_int_o
);

   logic [31:0] pend_secs;
   logic [31:0] pend_ticks;
   logic        ctrl_now;
   logic        ctrl_changed;
   logic [31:0] seconds;
   logic [31:0] ticks;
   logic        armed;
   logic        load_now;
   logic        load_pps;
   logic        last_tick;
   logic [1:0]  pps_sync;
   logic        pps_prev;
   logic        pps_edge;

   //////////////////////////////////////////////////
   // Pending time and control word
   //////////////////////////////////////////////////
   setting_reg #(.ADDR(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_SECS_OFS), .WIDTH(32)) u_sr_secs (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(pend_secs), .changed_o());

   setting_reg #(.ADDR(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TICKS_OFS), .WIDTH(32)) u_sr_ticks (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(pend_ticks), .changed_o());

   // Bit 0 set means load now, clear means wait for PPS
   setting_reg #(.ADDR(sr_map_pkg::SR_TIME64 + sr_map_pkg::SR_TIME_CTRL_OFS), .WIDTH(1)) u_sr_ctrl (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(ctrl_now), .changed_o(ctrl_changed));

   assign load_now  = ctrl_changed & ctrl_now;
   assign load_pps  = pps_edge & armed;
   assign last_tick = (ticks == (TICKS_PER_SEC - 32'd1));

   //////////////////////////////////////////////////
   // Seconds and ticks counter
   //////////////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         seconds <= '0;
         ticks   <= '0;
      end else if (load_now || load_pps) begin
         seconds <= pend_secs;
         ticks   <= pend_ticks;
      end else if (last_tick) begin
         seconds <= seconds + 32'd1;
         ticks   <= '0;
      end else begin
         ticks <= ticks + 32'd1;
      end
   end

   // A new control write overrides any earlier arm
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         armed <= 1'b0;
      end else if (ctrl_changed) begin
         armed <= ~ctrl_now;
      end else if (pps_edge) begin
         armed <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // PPS synchronizer, edge detect and capture
   //////////////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_sync        <= '0;
         pps_prev        <= 1'b0;
         pps_edge        <= 1'b0;
         vita_time_pps_o <= '0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_prev <= pps_sync[1];
         pps_edge <= pps_sync[1] & ~pps_prev;
         // Time seen during the detect cycle, before a PPS load lands
         if (pps_edge)
            vita_time_pps_o <= {seconds, ticks};
      end
   end

   assign vita_time_o = {seconds, ticks};
   assign pps_int_o   = pps_edge;

endmodule

//--- rtl/misc_ctrl.sv
/* Control bank for the board lines: clock generator, SERDES, ADC and PHY
   reset, plus the per-LED choice between hardware status and software. */

`timescale 1ns/1ns

module misc_ctrl (
   input  logic                              dsp_clk,
   input  logic                              rst_i,
   input  logic                              set_stb_i,
   input  logic [sr_map_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [sr_map_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                              clk_status_i,
   input  logic                              serdes_link_up_i,
   input  logic                              run_rx_i,
   input  logic                              run_tx_i,
   output logic                              clock_ready_o,
   output logic [1:0]                        clk_en_o,
   output logic [1:0]                        clk_sel_o,
   output logic                              ser_enable_o,
   output logic                              ser_prbsen_o,
   output logic                              ser_loopen_o,
   output logic                              ser_rx_en_o,
   output logic                              adc_oe_a_o,
   output logic                              adc_on_a_o,
   output logic                              adc_oe_b_o,
   output logic                              adc_on_b_o,
   output logic                              phy_resetn_o,
   output logic [7:0]                        leds_o
);

   logic [4:0] clock_outs;
   logic [3:0] serdes_outs;
   logic [3:0] adc_outs;
   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   //////////////////////////////////////////////////
   // Setting registers
   //////////////////////////////////////////////////
   setting_reg #(.ADDR(sr_map_pkg::SR_MISC + sr_map_pkg::SR_CLK_OFS), .WIDTH(5)) u_sr_clk (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(clock_outs), .changed_o());

   setting_reg #(.ADDR(sr_map_pkg::SR_MISC + sr_map_pkg::SR_SER_OFS), .WIDTH(4)) u_sr_ser (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(serdes_outs), .changed_o());

   setting_reg #(.ADDR(sr_map_pkg::SR_MISC + sr_map_pkg::SR_ADC_OFS), .WIDTH(4)) u_sr_adc (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(adc_outs), .changed_o());

   setting_reg #(.ADDR(sr_map_pkg::SR_MISC + sr_map_pkg::SR_LED_SW_OFS), .WIDTH(8)) u_sr_led_sw (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(led_sw), .changed_o());

   // PHY held in reset until software releases it
   setting_reg #(.ADDR(sr_map_pkg::SR_MISC + sr_map_pkg::SR_PHY_OFS), .WIDTH(1),
                 .AT_RESET(1'b1)) u_sr_phy (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(phy_reset), .changed_o());

   setting_reg #(.ADDR(sr_map_pkg::SR_MISC + sr_map_pkg::SR_LED_SRC_OFS), .WIDTH(8),
                 .AT_RESET(sr_map_pkg::LED_SRC_AT_RESET)) u_sr_led_src (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(led_src), .changed_o());

   //////////////////////////////////////////////////
   // Board control lines
   //////////////////////////////////////////////////
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_outs;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_outs;
   assign phy_resetn_o = ~phy_reset;

   // Hardware status byte, top three LEDs and bit 0 have no source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};

   // Mask bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- rtl/setting_reg.sv
/* One setting register on the settings bus. Latches the low WIDTH bits of
   the data word when the address matches and pulses changed_o once. */

`timescale 1ns/1ns

module setting_reg #(
   parameter logic [sr_map_pkg::SET_ADDR_W-1:0] ADDR = '0,
   parameter int WIDTH = 32,
   parameter logic [WIDTH-1:0] AT_RESET = '0
) (
   input  logic                            dsp_clk,
   input  logic                            rst_i,
   input  logic                            set_stb_i,
   input  logic [sr_map_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [sr_map_pkg::SET_DATA_W-1:0] set_data_i,
   output logic [WIDTH-1:0]                out_o,
   output logic                            changed_o
);

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         out_o     <= AT_RESET;
         changed_o <= 1'b0;
      end else if (set_stb_i && (set_addr_i == ADDR)) begin
         out_o     <= set_data_i[WIDTH-1:0];
         changed_o <= 1'b1;
      end else begin
         changed_o <= 1'b0;
      end
   end

endmodule

//--- rtl/readback_pkg.sv
/* Readback word indices, the compatibility number and the bit layout of
   the interrupt source word, shared by the readback mux and its users. */

package readback_pkg;

   // Index into the 16 readback words
   localparam int RB_ADDR_W = 4;

   //////////////////////////////////////////////////
   // Word indices, 0 to 8 read as zero
   //////////////////////////////////////////////////
   localparam logic [RB_ADDR_W-1:0] RB_MODE    = 4'd9;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_HI = 4'd10;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_LO = 4'd11;
   localparam logic [RB_ADDR_W-1:0] RB_COMPAT  = 4'd12;
   localparam logic [RB_ADDR_W-1:0] RB_IRQ     = 4'd13;
   localparam logic [RB_ADDR_W-1:0] RB_PPS_HI  = 4'd14;
   localparam logic [RB_ADDR_W-1:0] RB_PPS_LO  = 4'd15;

   // Bump when the register map changes in a way software must know about
   localparam logic [31:0] COMPAT_NUM = 32'd5;

   //////////////////////////////////////////////////
   // Interrupt source word bit positions
   //////////////////////////////////////////////////
   localparam int IRQ_PHY_BIT    = 4;
   localparam int IRQ_PPS_BIT    = 7;
   localparam int IRQ_SERDES_BIT = 10;
   localparam int IRQ_CLK_BIT    = 11;

endpackage

//--- rtl/sr_map_pkg.sv
/* Settings bus widths and the address map of the setting registers.
   Modules refer to these by scoped name to place their registers on the bus. */

package sr_map_pkg;

   // Settings bus geometry
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   //////////////////////////////////////////////////
   // Control bank, board lines and LEDs
   //////////////////////////////////////////////////
   localparam logic [SET_ADDR_W-1:0] SR_MISC        = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_CLK_OFS     = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_SER_OFS     = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_ADC_OFS     = 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SW_OFS  = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_PHY_OFS     = 8'd4;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC_OFS = 8'd8;

   //////////////////////////////////////////////////
   // VITA time keeper
   //////////////////////////////////////////////////
   localparam logic [SET_ADDR_W-1:0] SR_TIME64        = 8'd192;
   localparam logic [SET_ADDR_W-1:0] SR_SECS_OFS      = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_TICKS_OFS     = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_CTRL_OFS = 8'd2;

   // 1 selects the hardware source for that LED
   localparam logic [7:0] LED_SRC_AT_RESET = 8'b0001_1110;

endpackage
